//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_gaussian_pyramid
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- gauss_blur.sv
module gauss_blur
    import pyr_pkg::*;
#(
    parameter int WIDTH  = TOP_WIDTH,
    parameter int HEIGHT = TOP_HEIGHT
) (
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   start,
    output logic   rd_en,
    output addr_t  rd_addr,
    input  pixel_t rd_data,
    output logic   wr_en,
    output addr_t  wr_addr,
    output pixel_t wr_data,
    output logic   done
);

    localparam int PIXELS   = WIDTH * HEIGHT;
    localparam int ACC_BITS = PIXEL_BITS + BLUR_SHIFT;

    addr_t rd_x, rd_y;                  // output pixel being fetched
    logic [1:0] rd_dx, rd_dy;           // tap offset plus one
    logic last_read;
    int cx, cy;

    logic [READ_LATENCY-1:0] vld_pipe;  // rd_en delayed to the data return
    logic [1:0] ret_dx, ret_dy;         // tap of the returning data
    addr_t ret_pix;
    logic ret_last_tap;
    logic [1:0] tap_sh;                 // log2 of the kernel weight
    logic [ACC_BITS-1:0] acc, tap_val;

    // neighbour coordinate clamped to the image
    always_comb begin
        cx = int'(rd_x) + int'(rd_dx) - 1;
        cy = int'(rd_y) + int'(rd_dy) - 1;
        if (cx < 0) begin
            cx = 0;
        end else if (cx > WIDTH - 1) begin
            cx = WIDTH - 1;
        end
        if (cy < 0) begin
            cy = 0;
        end else if (cy > HEIGHT - 1) begin
            cy = HEIGHT - 1;
        end
        rd_addr = addr_t'(cy * WIDTH + cx);
    end

    assign last_read = rd_dx == 2'd2 && rd_dy == 2'd2 &&
                       rd_x == addr_t'(WIDTH - 1) && rd_y == addr_t'(HEIGHT - 1);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_en <= 1'b0;
            rd_x  <= '0;
            rd_y  <= '0;
            rd_dx <= '0;
            rd_dy <= '0;
        end else if (start) begin
            rd_en <= 1'b1;
            rd_x  <= '0;
            rd_y  <= '0;
            rd_dx <= '0;
            rd_dy <= '0;
        end else if (rd_en) begin
            if (last_read) begin
                rd_en <= 1'b0;
            end
            if (rd_dx != 2'd2) begin
                rd_dx <= rd_dx + 2'd1;
            end else begin
                rd_dx <= '0;
                if (rd_dy != 2'd2) begin
                    rd_dy <= rd_dy + 2'd1;
                end else begin
                    rd_dy <= '0;
                    if (rd_x != addr_t'(WIDTH - 1)) begin
                        rd_x <= rd_x + 1'b1;
                    end else begin
                        rd_x <= '0;
                        rd_y <= rd_y + 1'b1;
                    end
                end
            end
        end
    end

    assign ret_last_tap = ret_dx == 2'd2 && ret_dy == 2'd2;
    assign tap_sh  = {1'b0, ret_dx == 2'd1} + {1'b0, ret_dy == 2'd1};
    assign tap_val = ACC_BITS'(rd_data) << tap_sh;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            vld_pipe <= '0;
            ret_dx   <= '0;
            ret_dy   <= '0;
            ret_pix  <= '0;
            wr_en    <= 1'b0;
            done     <= 1'b0;
        end else begin
            vld_pipe <= {vld_pipe[READ_LATENCY-2:0], rd_en};
            wr_en    <= 1'b0;
            done     <= wr_en && wr_addr == addr_t'(PIXELS - 1);
            if (start) begin
                ret_dx  <= '0;
                ret_dy  <= '0;
                ret_pix <= '0;
            end else if (vld_pipe[READ_LATENCY-1]) begin
                ret_dx <= (ret_dx == 2'd2) ? 2'd0 : ret_dx + 2'd1;
                if (ret_dx == 2'd2) begin
                    ret_dy <= (ret_dy == 2'd2) ? 2'd0 : ret_dy + 2'd1;
                end
                if (ret_last_tap) begin
                    wr_en   <= 1'b1;
                    ret_pix <= ret_pix + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (vld_pipe[READ_LATENCY-1]) begin
            acc <= (ret_dx == 2'd0 && ret_dy == 2'd0) ? tap_val : acc + tap_val;
            if (ret_last_tap) begin  // round to nearest
                wr_data <= pixel_t'((acc + tap_val + ACC_BITS'(1 << (BLUR_SHIFT - 1)))
                                    >> BLUR_SHIFT);
                wr_addr <= ret_pix;
            end
        end
    end

endmodule

//--- gaussian_pyramid.sv
module gaussian_pyramid
    import pyr_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   start_in,
    output logic   src_rd_en,
    output addr_t  src_rd_addr,
    input  pixel_t src_rd_data,
    output logic   lvl_wr_en,
    output level_t lvl_level,
    output addr_t  lvl_wr_addr,
    output pixel_t lvl_wr_data,
    output logic   pyramid_done
);

    logic   a1_wr_en, a1_rd_en, a2_wr_en, a2_rd_en;
    logic   b1_wr_en, b1_rd_en, b2_wr_en, b2_rd_en;
    addr_t  a1_wr_addr, a1_rd_addr, a2_wr_addr, a2_rd_addr;
    addr_t  b1_wr_addr, b1_rd_addr, b2_wr_addr, b2_rd_addr;
    pixel_t a1_wr_data, a2_wr_data, b1_wr_data, b2_wr_data;
    pixel_t a1_rd_data, a2_rd_data, b1_rd_data, b2_rd_data;

    logic   blur_full_start, blur_full_done, blur_full_rd_en, blur_full_wr_en;
    logic   blur_half_start, blur_half_done, blur_half_rd_en, blur_half_wr_en;
    logic   down_start, down_done, down_rd_en, down_wr_en;
    addr_t  blur_full_rd_addr, blur_full_wr_addr, blur_half_rd_addr, blur_half_wr_addr;
    addr_t  down_rd_addr, down_wr_addr;
    pixel_t blur_full_rd_data, blur_full_wr_data, blur_half_rd_data, blur_half_wr_data;
    pixel_t down_rd_data, down_wr_data;

    // full-size ping-pong pair
    pyr_ram #(.DEPTH(TOP_PIXELS)) a1 (.clk_in, .wr_en(a1_wr_en), .wr_addr(a1_wr_addr),
        .wr_data(a1_wr_data), .rd_en(a1_rd_en), .rd_addr(a1_rd_addr), .rd_data(a1_rd_data));
    pyr_ram #(.DEPTH(TOP_PIXELS)) a2 (.clk_in, .wr_en(a2_wr_en), .wr_addr(a2_wr_addr),
        .wr_data(a2_wr_data), .rd_en(a2_rd_en), .rd_addr(a2_rd_addr), .rd_data(a2_rd_data));

    // half-size pair
    pyr_ram #(.DEPTH(TOP_PIXELS / 4)) b1 (.clk_in, .wr_en(b1_wr_en), .wr_addr(b1_wr_addr),
        .wr_data(b1_wr_data), .rd_en(b1_rd_en), .rd_addr(b1_rd_addr), .rd_data(b1_rd_data));
    pyr_ram #(.DEPTH(TOP_PIXELS / 4)) b2 (.clk_in, .wr_en(b2_wr_en), .wr_addr(b2_wr_addr),
        .wr_data(b2_wr_data), .rd_en(b2_rd_en), .rd_addr(b2_rd_addr), .rd_data(b2_rd_data));

    gauss_blur #(.WIDTH(TOP_WIDTH), .HEIGHT(TOP_HEIGHT)) blur_full (.clk_in, .rst_in,
        .start(blur_full_start), .rd_en(blur_full_rd_en), .rd_addr(blur_full_rd_addr),
        .rd_data(blur_full_rd_data), .wr_en(blur_full_wr_en), .wr_addr(blur_full_wr_addr),
        .wr_data(blur_full_wr_data), .done(blur_full_done));

    gauss_blur #(.WIDTH(TOP_WIDTH / 2), .HEIGHT(TOP_HEIGHT / 2)) blur_half (.clk_in, .rst_in,
        .start(blur_half_start), .rd_en(blur_half_rd_en), .rd_addr(blur_half_rd_addr),
        .rd_data(blur_half_rd_data), .wr_en(blur_half_wr_en), .wr_addr(blur_half_wr_addr),
        .wr_data(blur_half_wr_data), .done(blur_half_done));

    half_downsample #(.OLD_WIDTH(TOP_WIDTH), .OLD_HEIGHT(TOP_HEIGHT)) down (.clk_in, .rst_in,
        .start(down_start), .rd_en(down_rd_en), .rd_addr(down_rd_addr),
        .rd_data(down_rd_data), .wr_en(down_wr_en), .wr_addr(down_wr_addr),
        .wr_data(down_wr_data), .done(down_done));

    pyramid_sequencer sequencer (.*);  // wire names match its ports

endmodule

//--- half_downsample.sv
module half_downsample
    import pyr_pkg::*;
#(
    parameter int OLD_WIDTH  = TOP_WIDTH,
    parameter int OLD_HEIGHT = TOP_HEIGHT
) (
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   start,
    output logic   rd_en,
    output addr_t  rd_addr,
    input  pixel_t rd_data,
    output logic   wr_en,
    output addr_t  wr_addr,
    output pixel_t wr_data,
    output logic   done
);

    localparam int NEW_WIDTH  = OLD_WIDTH / 2;
    localparam int NEW_HEIGHT = OLD_HEIGHT / 2;
    localparam int NEW_PIXELS = NEW_WIDTH * NEW_HEIGHT;
    localparam int SUM_BITS   = PIXEL_BITS + 2;

    addr_t rd_x, rd_y;                  // half-size coordinate being fetched
    logic [1:0] rd_tap;                 // bit 0 picks the column, bit 1 the row
    logic last_read;

    logic [READ_LATENCY-1:0] vld_pipe;
    logic [1:0] ret_tap;
    addr_t ret_pix;
    logic [SUM_BITS-1:0] acc, tap_val;

    assign rd_addr = addr_t'((2 * rd_y + rd_tap[1]) * OLD_WIDTH + 2 * rd_x + rd_tap[0]);
    assign last_read = rd_tap == 2'd3 &&
                       rd_x == addr_t'(NEW_WIDTH - 1) && rd_y == addr_t'(NEW_HEIGHT - 1);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_en  <= 1'b0;
            rd_x   <= '0;
            rd_y   <= '0;
            rd_tap <= '0;
        end else if (start) begin
            rd_en  <= 1'b1;
            rd_x   <= '0;
            rd_y   <= '0;
            rd_tap <= '0;
        end else if (rd_en) begin
            if (last_read) begin
                rd_en <= 1'b0;
            end
            rd_tap <= rd_tap + 2'd1;  // wraps after the fourth tap
            if (rd_tap == 2'd3) begin
                if (rd_x != addr_t'(NEW_WIDTH - 1)) begin
                    rd_x <= rd_x + 1'b1;
                end else begin
                    rd_x <= '0;
                    rd_y <= rd_y + 1'b1;
                end
            end
        end
    end

    assign tap_val = SUM_BITS'(rd_data);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            vld_pipe <= '0;
            ret_tap  <= '0;
            ret_pix  <= '0;
            wr_en    <= 1'b0;
            done     <= 1'b0;
        end else begin
            vld_pipe <= {vld_pipe[READ_LATENCY-2:0], rd_en};
            wr_en    <= 1'b0;
            done     <= wr_en && wr_addr == addr_t'(NEW_PIXELS - 1);
            if (start) begin
                ret_tap <= '0;
                ret_pix <= '0;
            end else if (vld_pipe[READ_LATENCY-1]) begin
                ret_tap <= ret_tap + 2'd1;
                if (ret_tap == 2'd3) begin
                    wr_en   <= 1'b1;
                    ret_pix <= ret_pix + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (vld_pipe[READ_LATENCY-1]) begin
            acc <= (ret_tap == 2'd0) ? tap_val : acc + tap_val;
            if (ret_tap == 2'd3) begin
                wr_data <= pixel_t'((acc + tap_val + SUM_BITS'(2)) >> 2);  // rounded mean
                wr_addr <= ret_pix;
            end
        end
    end

endmodule

//--- list.f
pyr_pkg.sv
pyr_ram.sv
gauss_blur.sv
half_downsample.sv
pyramid_sequencer.sv
gaussian_pyramid.sv
tb_gaussian_pyramid.sv

//--- pyr_pkg.sv
package pyr_pkg;

    localparam int PIXEL_BITS = 8;  // greyscale depth
    localparam int TOP_WIDTH  = 8;
    localparam int TOP_HEIGHT = 8;
    localparam int TOP_PIXELS = TOP_WIDTH * TOP_HEIGHT;
    localparam int ADDR_BITS  = $clog2(TOP_PIXELS);

    localparam int NUM_LEVELS = 6;  // two octaves of three levels

    // source memory and level buffers share one read latency
    localparam int READ_LATENCY = 2;

    // 1 2 1 / 2 4 2 / 1 2 1 kernel sums to 16
    localparam int BLUR_SHIFT = 4;

    typedef logic [PIXEL_BITS-1:0] pixel_t;
    typedef logic [ADDR_BITS-1:0]  addr_t;   // half-size levels use the low bits
    typedef logic [2:0]            level_t;

endpackage

//--- pyr_ram.sv
module pyr_ram
    import pyr_pkg::*;
#(
    parameter int DEPTH = TOP_PIXELS
) (
    input  logic   clk_in,
    input  logic   wr_en,
    input  addr_t  wr_addr,
    input  pixel_t wr_data,
    input  logic   rd_en,
    input  addr_t  rd_addr,
    output pixel_t rd_data
);

    localparam int IDX_BITS = $clog2(DEPTH);

    pixel_t mem [DEPTH];
    logic [IDX_BITS-1:0] rd_idx_q;  // first read stage

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr[IDX_BITS-1:0]] <= wr_data;
        end
        if (rd_en) begin
            rd_idx_q <= rd_addr[IDX_BITS-1:0];
        end
        rd_data <= mem[rd_idx_q];  // second stage, data two cycles after rd_en
    end

endmodule

//--- pyr_stim.txt
// each line is one image row, one hex pixel per column, left to right
// blocks in order: source (also level 0) 8x8, level 1 8x8, level 2 8x8, levels 3 4 5 at 4x4
// source
05 1A 03 40 22 7F 11 09
15 2A 13 50 32 8F 21 19
25 3A 23 60 42 9F 31 29
35 4A 33 70 52 AF 41 39
45 5A 43 80 62 BF 51 49
55 6A 53 90 72 CF 61 59
65 7A 63 A0 82 DF 71 69
75 8A 73 B0 92 EF 81 79
// level 1
0E 13 1C 2D 45 50 2F 0F
1A 1F 28 39 51 5C 3B 1B
2A 2F 38 49 61 6C 4B 2B
3A 3F 48 59 71 7C 5B 3B
4A 4F 58 69 81 8C 6B 4B
5A 5F 68 79 91 9C 7B 5B
6A 6F 78 89 A1 AC 8B 6B
76 7B 84 95 AD B8 97 77
// level 2
12 17 21 32 45 48 32 1A
1C 21 2B 3C 4F 52 3C 24
2B 30 3A 4B 5E 61 4B 33
3B 40 4A 5B 6E 71 5B 43
4B 50 5A 6B 7E 81 6B 53
5B 60 6A 7B 8E 91 7B 63
6A 6F 79 8A 9D A0 8A 72
74 79 83 94 A7 AA 94 7C
// level 3
1A 2F 4C 2B
36 4B 68 47
56 6B 88 67
72 87 A4 83
// level 4
26 38 44 3A
3C 4E 5A 50
5A 6C 78 6E
70 82 8E 84
// level 5
30 3C 44 42
43 4F 57 55
5D 69 71 6F
6F 7B 83 81

//--- pyramid_sequencer.sv
module pyramid_sequencer
    import pyr_pkg::*;
(
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   start_in,
    output logic   pyramid_done,

    output logic   src_rd_en,
    output addr_t  src_rd_addr,
    input  pixel_t src_rd_data,

    output logic   blur_full_start, blur_half_start, down_start,
    input  logic   blur_full_done, blur_half_done, down_done,

    input  logic   blur_full_rd_en, blur_full_wr_en,
    input  addr_t  blur_full_rd_addr, blur_full_wr_addr,
    input  pixel_t blur_full_wr_data,
    output pixel_t blur_full_rd_data,
    input  logic   blur_half_rd_en, blur_half_wr_en,
    input  addr_t  blur_half_rd_addr, blur_half_wr_addr,
    input  pixel_t blur_half_wr_data,
    output pixel_t blur_half_rd_data,
    input  logic   down_rd_en, down_wr_en,
    input  addr_t  down_rd_addr, down_wr_addr,
    input  pixel_t down_wr_data,
    output pixel_t down_rd_data,

    output logic   a1_wr_en, a1_rd_en, a2_wr_en, a2_rd_en,
    output logic   b1_wr_en, b1_rd_en, b2_wr_en, b2_rd_en,
    output addr_t  a1_wr_addr, a1_rd_addr, a2_wr_addr, a2_rd_addr,
    output addr_t  b1_wr_addr, b1_rd_addr, b2_wr_addr, b2_rd_addr,
    output pixel_t a1_wr_data, a2_wr_data, b1_wr_data, b2_wr_data,
    input  pixel_t a1_rd_data, a2_rd_data, b1_rd_data, b2_rd_data,

    output logic   lvl_wr_en,
    output level_t lvl_level,
    output addr_t  lvl_wr_addr,
    output pixel_t lvl_wr_data
);

    localparam level_t LAST_LEVEL = level_t'(NUM_LEVELS - 1);

    // phase states carry their level number
    typedef enum logic [2:0] {
        S_PH0  = 3'd0,
        S_PH1  = 3'd1,
        S_PH2  = 3'd2,
        S_PH3  = 3'd3,
        S_PH4  = 3'd4,
        S_PH5  = 3'd5,
        S_IDLE = 3'd7
    } state_t;

    state_t state;
    logic [READ_LATENCY-1:0] src_vld_pipe;
    addr_t src_addr_pipe [READ_LATENCY];
    logic src_wr_en;
    addr_t src_wr_addr;

    assign src_wr_en   = src_vld_pipe[READ_LATENCY-1];
    assign src_wr_addr = src_addr_pipe[READ_LATENCY-1];

    always_ff @(posedge clk_in) begin
        src_addr_pipe[0] <= src_rd_addr;
        for (int i = 1; i < READ_LATENCY; i++) begin
            src_addr_pipe[i] <= src_addr_pipe[i-1];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state           <= S_IDLE;
            src_rd_en       <= 1'b0;
            src_rd_addr     <= '0;
            src_vld_pipe    <= '0;
            blur_full_start <= 1'b0;
            blur_half_start <= 1'b0;
            down_start      <= 1'b0;
        end else begin
            src_vld_pipe    <= {src_vld_pipe[READ_LATENCY-2:0], src_rd_en};
            blur_full_start <= 1'b0;
            blur_half_start <= 1'b0;
            down_start      <= 1'b0;
            case (state)
                S_IDLE: if (start_in) begin
                    state       <= S_PH0;
                    src_rd_en   <= 1'b1;
                    src_rd_addr <= '0;
                end
                S_PH0: begin  // copy the source image, one read per cycle
                    if (src_rd_en) begin
                        if (src_rd_addr == addr_t'(TOP_PIXELS - 1)) begin
                            src_rd_en <= 1'b0;
                        end else begin
                            src_rd_addr <= src_rd_addr + 1'b1;
                        end
                    end
                    if (src_wr_en && src_wr_addr == addr_t'(TOP_PIXELS - 1)) begin
                        state           <= S_PH1;
                        blur_full_start <= 1'b1;
                    end
                end
                S_PH1: if (blur_full_done) begin
                    state           <= S_PH2;
                    blur_full_start <= 1'b1;
                end
                S_PH2: if (blur_full_done) begin
                    state      <= S_PH3;
                    down_start <= 1'b1;
                end
                S_PH3: if (down_done) begin
                    state           <= S_PH4;
                    blur_half_start <= 1'b1;
                end
                S_PH4: if (blur_half_done) begin
                    state           <= S_PH5;
                    blur_half_start <= 1'b1;
                end
                S_PH5: if (blur_half_done) begin
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // done lands one cycle after the last level-5 write
    assign pyramid_done = level_t'(state) == LAST_LEVEL && blur_half_done;
    assign lvl_level    = (state == S_IDLE) ? '0 : level_t'(state);

    // active writer of the phase, mirrored to the level port
    always_comb begin
        case (state)
            S_PH0: begin
                lvl_wr_en   = src_wr_en;
                lvl_wr_addr = src_wr_addr;
                lvl_wr_data = src_rd_data;
            end
            S_PH1, S_PH2: begin
                lvl_wr_en   = blur_full_wr_en;
                lvl_wr_addr = blur_full_wr_addr;
                lvl_wr_data = blur_full_wr_data;
            end
            S_PH3: begin
                lvl_wr_en   = down_wr_en;
                lvl_wr_addr = down_wr_addr;
                lvl_wr_data = down_wr_data;
            end
            S_PH4, S_PH5: begin
                lvl_wr_en   = blur_half_wr_en;
                lvl_wr_addr = blur_half_wr_addr;
                lvl_wr_data = blur_half_wr_data;
            end
            default: begin
                lvl_wr_en   = 1'b0;
                lvl_wr_addr = '0;
                lvl_wr_data = '0;
            end
        endcase
    end

    assign a1_wr_en = lvl_wr_en && (state == S_PH0 || state == S_PH2);
    assign a2_wr_en = lvl_wr_en && state == S_PH1;
    assign b1_wr_en = lvl_wr_en && (state == S_PH3 || state == S_PH5);
    assign b2_wr_en = lvl_wr_en && state == S_PH4;
    assign a1_wr_addr = lvl_wr_addr;
    assign a2_wr_addr = lvl_wr_addr;
    assign b1_wr_addr = lvl_wr_addr;
    assign b2_wr_addr = lvl_wr_addr;
    assign a1_wr_data = lvl_wr_data;
    assign a2_wr_data = lvl_wr_data;
    assign b1_wr_data = lvl_wr_data;
    assign b2_wr_data = lvl_wr_data;

    // read side, one reader per phase
    assign a1_rd_en   = (state == S_PH1 && blur_full_rd_en) || (state == S_PH3 && down_rd_en);
    assign a1_rd_addr = (state == S_PH3) ? down_rd_addr : blur_full_rd_addr;
    assign a2_rd_en   = state == S_PH2 && blur_full_rd_en;
    assign a2_rd_addr = blur_full_rd_addr;
    assign b1_rd_en   = state == S_PH4 && blur_half_rd_en;
    assign b1_rd_addr = blur_half_rd_addr;
    assign b2_rd_en   = state == S_PH5 && blur_half_rd_en;
    assign b2_rd_addr = blur_half_rd_addr;

    assign blur_full_rd_data = (state == S_PH1) ? a1_rd_data : a2_rd_data;
    assign blur_half_rd_data = (state == S_PH4) ? b1_rd_data : b2_rd_data;
    assign down_rd_data      = a1_rd_data;

endmodule

//--- tb_gaussian_pyramid.sv
module tb_gaussian_pyramid
    import pyr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PIXELS = TOP_PIXELS / 4;
    localparam int STIM_WORDS  = 3 * TOP_PIXELS + 3 * HALF_PIXELS;
    // one run: copy, two full blurs of 9 reads, downsample of 4 reads, two half blurs
    localparam int RUN_CYCLES  = TOP_PIXELS + 2 * 9 * TOP_PIXELS + 4 * HALF_PIXELS
                                 + 2 * 9 * HALF_PIXELS;
    localparam int CYCLE_LIMIT = 2 * RUN_CYCLES + 1000;

    logic   clk_in = 1'b0;
    logic   rst_in;
    logic   start_in;
    logic   src_rd_en;
    addr_t  src_rd_addr;
    pixel_t src_rd_data = '0;
    logic   lvl_wr_en;
    level_t lvl_level;
    addr_t  lvl_wr_addr;
    pixel_t lvl_wr_data;
    logic   pyramid_done;

    pixel_t stim_mem [STIM_WORDS];   // source first, then expected levels 1 to 5
    pixel_t got_mem [STIM_WORDS];    // same layout, filled from the level port
    pixel_t first_run [STIM_WORDS];
    logic   written [STIM_WORDS];
    int     wr_count [NUM_LEVELS];
    addr_t  src_pipe [READ_LATENCY];
    logic [READ_LATENCY-1:0] src_en_pipe = '0;  // read enable beside the address
    level_t last_level;
    logic   prev_last_write;
    int     done_count;
    int     cycle_count = 0;
    int     seed;

    gaussian_pyramid UUT (.*);

    initial begin
        forever #10 clk_in = ~clk_in;
    end

    function automatic int level_pixels(input level_t lvl);
        return (lvl < 3) ? TOP_PIXELS : HALF_PIXELS;
    endfunction

    function automatic int level_base(input level_t lvl);
        if (lvl < 3) begin
            return int'(lvl) * TOP_PIXELS;
        end
        return 3 * TOP_PIXELS + (int'(lvl) - 3) * HALF_PIXELS;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_level(input string name, input level_t got, input level_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // source memory, data appears READ_LATENCY cycles after a read
    always @(negedge clk_in) begin
        src_pipe[0] <= src_rd_addr;
        for (int i = 1; i < READ_LATENCY; i++) begin
            src_pipe[i] <= src_pipe[i-1];
        end
        src_en_pipe <= {src_en_pipe[READ_LATENCY-2:0], src_rd_en};
        if (src_en_pipe[READ_LATENCY-1]) begin
            src_rd_data <= stim_mem[src_pipe[READ_LATENCY-1]];
        end else begin
            src_rd_data <= 'x;  // no read was issued
        end
    end

    // level port capture, sampled at the rising edge
    always @(posedge clk_in) begin
        int idx;
        if (!rst_in && pyramid_done) begin
            done_count = done_count + 1;
            check_flag("level 5 last write before pyramid_done", prev_last_write, 1'b1);
            check_count("level 5 writes minus one", addr_t'(wr_count[5] - 1),
                        addr_t'(HALF_PIXELS - 1));
        end
        prev_last_write = lvl_wr_en && lvl_level == level_t'(5) &&
                          lvl_wr_addr == addr_t'(HALF_PIXELS - 1);
        if (!rst_in && lvl_wr_en) begin
            if (int'(lvl_level) >= NUM_LEVELS) begin
                report_failure("level number out of range on the level port");
            end
            if (lvl_level < last_level) begin
                check_level("lvl_level", lvl_level, last_level);  // went backwards
            end
            if (int'(lvl_wr_addr) >= level_pixels(lvl_level)) begin
                report_failure("write address beyond the size of its level");
            end
            idx = level_base(lvl_level) + int'(lvl_wr_addr);
            if (written[idx]) begin
                report_failure("same address written twice within one level");
            end
            written[idx] = 1'b1;
            got_mem[idx] = lvl_wr_data;
            wr_count[lvl_level] = wr_count[lvl_level] + 1;
            last_level = lvl_level;
        end
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: pyramid_done not seen within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // one full pyramid, optionally with a stray start while busy
    task automatic run_pyramid(input bit stray_start);
        int stray_at;
        int waited;
        for (int i = 0; i < STIM_WORDS; i++) begin
            written[i] = 1'b0;
            got_mem[i] = 'x;
        end
        for (int l = 0; l < NUM_LEVELS; l++) begin
            wr_count[l] = 0;
        end
        last_level = '0;
        done_count = 0;
        stray_at = 100 + (($random(seed) & 32'h7fff_ffff) % 400);
        start_in = 1'b1;
        @(negedge clk_in);
        start_in = 1'b0;
        waited = 1;
        while (done_count == 0) begin
            start_in = stray_start && waited == stray_at;
            @(negedge clk_in);
            waited++;
        end
        start_in = 1'b0;
        repeat (6) @(negedge clk_in);  // room for a second done
        check_count("pyramid_done pulses", addr_t'(done_count), addr_t'(1));
    endtask

    task automatic check_levels();
        level_t lvl;
        int base;
        for (int l = 0; l < NUM_LEVELS; l++) begin
            lvl  = level_t'(l);
            base = level_base(lvl);
            check_count($sformatf("level %0d writes minus one", l),
                        addr_t'(wr_count[l] - 1), addr_t'(level_pixels(lvl) - 1));
            for (int a = 0; a < level_pixels(lvl); a++) begin
                check_pixel($sformatf("lvl_wr_data level %0d addr %0d", l, a),
                            got_mem[base + a], stim_mem[base + a]);
            end
        end
    endtask

    initial begin
        seed = 84;
        rst_in = 1'b1;
        start_in = 1'b0;
        last_level = '0;
        prev_last_write = 1'b0;
        done_count = 0;
        $readmemh("pyr_stim.txt", stim_mem);
        repeat (4) @(negedge clk_in);
        rst_in = 1'b0;
        check_flag("lvl_wr_en", lvl_wr_en, 1'b0);
        check_flag("src_rd_en", src_rd_en, 1'b0);
        check_flag("pyramid_done", pyramid_done, 1'b0);

        run_pyramid(1'b0);
        check_levels();
        for (int i = 0; i < STIM_WORDS; i++) begin
            first_run[i] = got_mem[i];
        end

        repeat (5) @(negedge clk_in);
        run_pyramid(1'b1);  // stray start must not restart the run
        check_levels();
        for (int i = 0; i < STIM_WORDS; i++) begin
            check_pixel($sformatf("lvl_wr_data second run word %0d", i),
                        got_mem[i], first_run[i]);
        end

        $display("Verification passed");
        $finish;
    end

endmodule
